// File: hw/mips_pkg.sv
// ####################
// shared package for the single-cycle core
// widths, reset pc, syscall constants
// opcode, funct, alu and load-select codes
// instruction union and control struct
// ####################

package mips_pkg;

   typedef logic [31:0] word_t;      // data or address word
   typedef logic [4:0]  reg_idx_t;   // gpr index

   localparam word_t    text_start   = 32'h0040_0000;  // pc after reset
   localparam reg_idx_t reg_v0       = 5'd2;           // syscall code register
   localparam word_t    syscall_exit = 32'd10;         // exit service number

   // primary opcodes kept by this core
   typedef enum logic [5:0] {
      op_special = 6'h00,
      op_j       = 6'h02,
      op_beq     = 6'h04,
      op_bne     = 6'h05,
      op_addi    = 6'h08,
      op_addiu   = 6'h09,
      op_slti    = 6'h0a,
      op_andi    = 6'h0c,
      op_ori     = 6'h0d,
      op_xori    = 6'h0e,
      op_lui     = 6'h0f,
      op_lb      = 6'h20,
      op_lh      = 6'h21,
      op_lw      = 6'h23,
      op_lbu     = 6'h24,
      op_lhu     = 6'h25,
      op_sw      = 6'h2b
   } opcode_t;

   // funct field of special instructions
   typedef enum logic [5:0] {
      fn_sll     = 6'h00,
      fn_srl     = 6'h02,
      fn_sra     = 6'h03,
      fn_sllv    = 6'h04,
      fn_srlv    = 6'h06,
      fn_srav    = 6'h07,
      fn_jr      = 6'h08,
      fn_syscall = 6'h0c,
      fn_add     = 6'h20,
      fn_addu    = 6'h21,
      fn_sub     = 6'h22,
      fn_subu    = 6'h23,
      fn_and     = 6'h24,
      fn_or      = 6'h25,
      fn_xor     = 6'h26,
      fn_nor     = 6'h27,
      fn_slt     = 6'h2a
   } funct_t;

   typedef enum logic [3:0] {
      alu_add, alu_sub,
      alu_sll, alu_srl, alu_sra,
      alu_sllv, alu_srlv, alu_srav,
      alu_and, alu_or, alu_xor, alu_nor,
      alu_slt, alu_lui
   } alu_sel_t;

   typedef enum logic [2:0] {ld_lb, ld_lh, ld_lw, ld_lbu, ld_lhu} load_sel_t;

   typedef enum logic [1:0] {pc_seq, pc_branch, pc_jump, pc_jreg} pc_sel_t;

   typedef enum logic {wb_alu, wb_load} wb_sel_t;

   // one instruction word, three field layouts
   typedef struct packed {
      opcode_t     op;
      reg_idx_t    rs;
      reg_idx_t    rt;
      reg_idx_t    rd;
      logic [4:0]  shamt;
      funct_t      funct;
   } inst_r_t;

   typedef struct packed {
      opcode_t     op;
      reg_idx_t    rs;
      reg_idx_t    rt;
      logic [15:0] imm;
   } inst_i_t;

   typedef struct packed {
      opcode_t     op;
      logic [25:0] target;   // word index within the 256MB region
   } inst_j_t;

   typedef union packed {
      inst_r_t r;
      inst_i_t i;
      inst_j_t j;
   } inst_t;

   // decoded control for one instruction
   typedef struct packed {
      logic      reg_we;           // gpr write
      logic      reg_dst_rd;       // dest is rd, else rt
      alu_sel_t  alu_sel;
      logic      alu_src_imm;      // operand b from immediate
      logic      imm_signed;       // sign-extend imm16
      logic      shift_by_shamt;   // shift count from shamt field
      wb_sel_t   wb_sel;
      load_sel_t load_sel;
      logic      mem_we;           // sw
      pc_sel_t   pc_sel;
      logic      branch_ne;        // bne, taken on inequality
      logic      is_syscall;
      logic      reserved;         // unknown opcode or funct
   } ctrl_t;

endpackage

// File: hw/mips_fetch.sv
// ####################
// program counter, next-pc mux
// and the halt flip-flop
// ####################

`timescale 1ns/1ps

module mips_fetch (
   input  logic            clk,
   input  logic            rst_b,
   input  mips_pkg::ctrl_t ctrl,
   input  logic            equal,      // rs == rt
   input  mips_pkg::word_t imm_ext,
   input  logic [25:0]     target,
   input  mips_pkg::word_t rs_data,
   input  logic            halt_req,
   output mips_pkg::word_t pc,
   output logic            halted
);
   import mips_pkg::*;

   word_t pc_plus4;
   word_t br_target;
   word_t j_target;
   word_t next_pc;
   logic  br_taken;

   assign pc_plus4  = pc + 32'd4;
   assign br_target = pc_plus4 + {imm_ext[29:0], 2'b00};   // offset in words
   assign j_target  = {pc_plus4[31:28], target, 2'b00};

   // beq taken on equal, bne on not equal
   assign br_taken = equal ^ ctrl.branch_ne;

   always_comb begin
      case (ctrl.pc_sel)
         pc_branch: next_pc = br_taken ? br_target : pc_plus4;
         pc_jump:   next_pc = j_target;
         pc_jreg:   next_pc = rs_data;
         default:   next_pc = pc_plus4;   // sequential, no delay slot
      endcase
   end

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         pc     <= text_start;
         halted <= 1'b0;
      end else begin
         if (!halted && !halt_req)   // pc parks on the halting instruction
            pc <= next_pc;
         if (halt_req)
            halted <= 1'b1;          // sticky until reset
      end
   end

endmodule

// File: hw/mips_decode.sv
// ####################
// instruction decoder
// opcode and funct to control struct
// ####################

`timescale 1ns/1ps

module mips_decode (
   input  mips_pkg::inst_t inst,
   output mips_pkg::ctrl_t ctrl
);
   import mips_pkg::*;

   always_comb begin
      ctrl = '0;   // add, lb, seq pc, alu writeback, no writes
      case (inst.r.op)
         op_special: begin
            ctrl.reg_we     = 1'b1;   // cleared below for jr, syscall, unknown
            ctrl.reg_dst_rd = 1'b1;
            case (inst.r.funct)
               fn_sll:  begin ctrl.alu_sel = alu_sll; ctrl.shift_by_shamt = 1'b1; end
               fn_srl:  begin ctrl.alu_sel = alu_srl; ctrl.shift_by_shamt = 1'b1; end
               fn_sra:  begin ctrl.alu_sel = alu_sra; ctrl.shift_by_shamt = 1'b1; end
               fn_sllv: ctrl.alu_sel = alu_sllv;   // count from rs[4:0]
               fn_srlv: ctrl.alu_sel = alu_srlv;
               fn_srav: ctrl.alu_sel = alu_srav;
               fn_add, fn_addu: ctrl.alu_sel = alu_add;   // no overflow trap
               fn_sub, fn_subu: ctrl.alu_sel = alu_sub;
               fn_and:  ctrl.alu_sel = alu_and;
               fn_or:   ctrl.alu_sel = alu_or;
               fn_xor:  ctrl.alu_sel = alu_xor;
               fn_nor:  ctrl.alu_sel = alu_nor;
               fn_slt:  ctrl.alu_sel = alu_slt;
               fn_jr: begin
                  ctrl.reg_we = 1'b0;
                  ctrl.pc_sel = pc_jreg;
               end
               fn_syscall: begin
                  ctrl.reg_we     = 1'b0;
                  ctrl.is_syscall = 1'b1;   // core checks v0
               end
               default: begin
                  ctrl.reg_we   = 1'b0;
                  ctrl.reserved = 1'b1;
               end
            endcase
         end
         op_addi, op_addiu, op_slti: begin
            ctrl.reg_we      = 1'b1;
            ctrl.alu_src_imm = 1'b1;
            ctrl.imm_signed  = 1'b1;
            ctrl.alu_sel     = (inst.i.op == op_slti) ? alu_slt : alu_add;
         end
         op_andi, op_ori, op_xori: begin
            ctrl.reg_we      = 1'b1;
            ctrl.alu_src_imm = 1'b1;   // zero-extended imm
            case (inst.i.op)
               op_andi: ctrl.alu_sel = alu_and;
               op_ori:  ctrl.alu_sel = alu_or;
               default: ctrl.alu_sel = alu_xor;
            endcase
         end
         op_lui: begin
            ctrl.reg_we      = 1'b1;
            ctrl.alu_src_imm = 1'b1;
            ctrl.alu_sel     = alu_lui;
         end
         op_lb, op_lh, op_lw, op_lbu, op_lhu: begin
            ctrl.reg_we      = 1'b1;
            ctrl.alu_src_imm = 1'b1;   // address = rs + sext(imm)
            ctrl.imm_signed  = 1'b1;
            ctrl.wb_sel      = wb_load;
            case (inst.i.op)
               op_lb:   ctrl.load_sel = ld_lb;
               op_lh:   ctrl.load_sel = ld_lh;
               op_lbu:  ctrl.load_sel = ld_lbu;
               op_lhu:  ctrl.load_sel = ld_lhu;
               default: ctrl.load_sel = ld_lw;
            endcase
         end
         op_sw: begin
            ctrl.mem_we      = 1'b1;
            ctrl.alu_src_imm = 1'b1;
            ctrl.imm_signed  = 1'b1;
         end
         op_beq, op_bne: begin
            ctrl.pc_sel     = pc_branch;
            ctrl.imm_signed = 1'b1;   // fetch needs sext offset
            ctrl.branch_ne  = (inst.i.op == op_bne);
         end
         op_j: ctrl.pc_sel = pc_jump;
         default: ctrl.reserved = 1'b1;   // every enable stays off
      endcase
   end

endmodule

// File: hw/mips_regfile.sv
// ####################
// general register file
// 32 x 32, 2 read, 1 write
// ####################

`timescale 1ns/1ps

module mips_regfile (
   input  logic               clk,
   input  logic               rst_b,
   input  mips_pkg::reg_idx_t rs_idx,
   input  mips_pkg::reg_idx_t rt_idx,
   input  logic               wr_en,
   input  mips_pkg::reg_idx_t wr_idx,
   input  mips_pkg::word_t    wr_data,
   output mips_pkg::word_t    rs_data,
   output mips_pkg::word_t    rt_data
);
   import mips_pkg::*;

   word_t regs [32];

   // $zero is cleared by reset and never written
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         for (int i = 0; i < 32; i++)
            regs[i] <= '0;
      end else if (wr_en && (wr_idx != '0)) begin
         regs[wr_idx] <= wr_data;
      end
   end

   // combinational reads, old value during a same-cycle write
   assign rs_data = regs[rs_idx];
   assign rt_data = regs[rt_idx];

endmodule

// File: hw/mips_alu.sv
// ####################
// immediate extension, operand mux
// alu and branch compare
// ####################

`timescale 1ns/1ps

module mips_alu (
   input  mips_pkg::ctrl_t ctrl,
   input  mips_pkg::inst_t inst,
   input  mips_pkg::word_t rs_data,
   input  mips_pkg::word_t rt_data,
   output mips_pkg::word_t alu_out,
   output mips_pkg::word_t imm_ext,
   output logic            equal
);
   import mips_pkg::*;

   word_t      op_b;
   logic [4:0] sh_amt;

   // sext for arithmetic, loads, stores, branches; zext for logic ops
   assign imm_ext = ctrl.imm_signed ? {{16{inst.i.imm[15]}}, inst.i.imm}
                                    : {16'h0000, inst.i.imm};

   assign op_b   = ctrl.alu_src_imm ? imm_ext : rt_data;
   assign sh_amt = ctrl.shift_by_shamt ? inst.r.shamt : rs_data[4:0];

   assign equal = (rs_data == rt_data);   // beq / bne

   always_comb begin
      case (ctrl.alu_sel)
         alu_add:  alu_out = rs_data + op_b;
         alu_sub:  alu_out = rs_data - op_b;
         alu_sll,
         alu_sllv: alu_out = rt_data << sh_amt;   // shifts act on rt
         alu_srl,
         alu_srlv: alu_out = rt_data >> sh_amt;
         alu_sra,
         alu_srav: alu_out = word_t'($signed(rt_data) >>> sh_amt);
         alu_and:  alu_out = rs_data & op_b;
         alu_or:   alu_out = rs_data | op_b;
         alu_xor:  alu_out = rs_data ^ op_b;
         alu_nor:  alu_out = ~(rs_data | op_b);
         alu_slt:  alu_out = {31'd0, $signed(rs_data) < $signed(op_b)};
         alu_lui:  alu_out = {inst.i.imm, 16'h0000};
         default:  alu_out = '0;
      endcase
   end

endmodule

// File: hw/mips_core.sv
// ####################
// single-cycle mips core, top level
// load alignment, writeback mux
// store port and syscall halt
// ####################

`timescale 1ns/1ps

module mips_core (
   input  logic            clk,
   input  logic            rst_b,
   input  mips_pkg::word_t inst,
   input  mips_pkg::word_t mem_data_out,
   output logic [29:0]     inst_addr,
   output logic [29:0]     mem_addr,
   output mips_pkg::word_t mem_data_in,
   output logic [3:0]      mem_write_en,
   output logic            halted
);
   import mips_pkg::*;

   inst_t      inst_u;
   ctrl_t      ctrl;
   word_t      pc;
   word_t      rs_data;
   word_t      rt_data;
   word_t      alu_out;
   word_t      imm_ext;
   word_t      load_data;
   word_t      wr_data;
   reg_idx_t   rs_idx;
   reg_idx_t   wr_idx;
   logic       equal;
   logic       halt_req;
   logic       wr_en;
   logic [7:0] byte_lane;
   logic [15:0] half_lane;

   assign inst_u    = inst;
   assign inst_addr = pc[31:2];

   mips_decode u_decode (
      .inst (inst_u),
      .ctrl (ctrl)
   );

   // syscall has rs = 0, so steer port a to v0 instead
   assign rs_idx = ctrl.is_syscall ? reg_v0 : inst_u.r.rs;
   assign wr_idx = ctrl.reg_dst_rd ? inst_u.r.rd : inst_u.r.rt;
   assign wr_en  = ctrl.reg_we & ~halted;

   mips_regfile u_regfile (
      .clk     (clk),
      .rst_b   (rst_b),
      .rs_idx  (rs_idx),
      .rt_idx  (inst_u.r.rt),
      .wr_en   (wr_en),
      .wr_idx  (wr_idx),
      .wr_data (wr_data),
      .rs_data (rs_data),
      .rt_data (rt_data)
   );

   mips_alu u_alu (
      .ctrl    (ctrl),
      .inst    (inst_u),
      .rs_data (rs_data),
      .rt_data (rt_data),
      .alu_out (alu_out),
      .imm_ext (imm_ext),
      .equal   (equal)
   );

   assign halt_req = ctrl.reserved | (ctrl.is_syscall && (rs_data == syscall_exit));

   mips_fetch u_fetch (
      .clk      (clk),
      .rst_b    (rst_b),
      .ctrl     (ctrl),
      .equal    (equal),
      .imm_ext  (imm_ext),
      .target   (inst_u.j.target),
      .rs_data  (rs_data),
      .halt_req (halt_req),
      .pc       (pc),
      .halted   (halted)
   );

   // data port, word aligned
   assign mem_addr     = alu_out[31:2];
   assign mem_data_in  = rt_data;
   assign mem_write_en = {4{ctrl.mem_we & ~halted}};   // sw only

   // little-endian lane pick
   assign byte_lane = mem_data_out[8*alu_out[1:0] +: 8];
   assign half_lane = alu_out[1] ? mem_data_out[31:16] : mem_data_out[15:0];

   always_comb begin
      case (ctrl.load_sel)
         ld_lb:   load_data = {{24{byte_lane[7]}}, byte_lane};
         ld_lbu:  load_data = {24'h00_0000, byte_lane};
         ld_lh:   load_data = {{16{half_lane[15]}}, half_lane};
         ld_lhu:  load_data = {16'h0000, half_lane};
         default: load_data = mem_data_out;   // lw
      endcase
   end

   assign wr_data = (ctrl.wb_sel == wb_load) ? load_data : alu_out;

endmodule

// File: sim/tb_mips_core.sv
// ####################
// testbench for the single-cycle core
// rom and ram models, program builder
// stimulus table, reference model, checks
// ####################

`timescale 1ns/1ps

module tb_mips_core;
   import mips_pkg::*;

   typedef enum logic [2:0] {k_r_alu, k_i_alu, k_load, k_branch, k_jump, k_sys, k_rsvd} kind_t;

   typedef struct packed {
      kind_t      kind;
      logic [5:0] code;    // opcode or the r_alu funct
      word_t      a;       // value in $8 (rs)
      word_t      b;       // value in $9 (rt), imm source, load word
      logic [4:0] aux;     // shamt or load byte offset
      int         n_exp;   // stores expected at word 0x40
      word_t      exp0;
      word_t      exp1;
   } row_t;

   logic        clk = 1'b0;
   logic        rst_b;
   word_t       inst;
   word_t       mem_data_out;
   logic [29:0] inst_addr;
   logic [29:0] mem_addr;
   word_t       mem_data_in;
   logic [3:0]  mem_write_en;
   logic        halted;
   word_t       rom [64];
   word_t       ram [256];
   word_t       ram_word;            // placed at byte 0x80 for loads
   logic [29:0] log_addr [$];
   word_t       log_data [$];
   row_t        rows [$];
   string       names [$];
   logic [5:0]  prog_idx;
   integer      seed = 12363;
   int          err_count = 0;
   int          fail_count = 0;

   always #50 clk = ~clk;   // 100 ns period

   mips_core UUT (
      .clk          (clk),
      .rst_b        (rst_b),
      .inst         (inst),
      .mem_data_out (mem_data_out),
      .inst_addr    (inst_addr),
      .mem_addr     (mem_addr),
      .mem_data_in  (mem_data_in),
      .mem_write_en (mem_write_en),
      .halted       (halted)
   );

   assign inst         = rom[inst_addr[5:0]];   // text_start is 64-word aligned
   assign mem_data_out = ram[mem_addr[7:0]];

   // data ram refilled and log cleared while reset is low
   always @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         for (int i = 0; i < 256; i++)
            ram[i[7:0]] <= {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, 8'hc3};
         ram[8'h20] <= ram_word;
         log_addr.delete();
         log_data.delete();
      end else if (mem_write_en != 4'h0) begin
         ram[mem_addr[7:0]] <= mem_data_in;
         log_addr.push_back(mem_addr);   // every write is logged
         log_data.push_back(mem_data_in);
      end
   end

   function automatic word_t rtype(reg_idx_t rs, reg_idx_t rt, reg_idx_t rd,
                                   logic [4:0] sh, logic [5:0] fn);
      return {6'h00, rs, rt, rd, sh, fn};
   endfunction

   function automatic word_t itype(logic [5:0] op, reg_idx_t rs, reg_idx_t rt, logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic word_t random_word();
      return $random(seed);
   endfunction

   // expected result from the isa rules
   function automatic word_t expected_word(kind_t k, logic [5:0] c, word_t a, word_t b,
                                           logic [4:0] aux);
      word_t       res;
      word_t       imm_s;
      word_t       imm_z;
      logic [4:0]  sh;
      logic [7:0]  by;
      logic [15:0] hw;
      imm_s = {{16{b[15]}}, b[15:0]};
      imm_z = {16'h0000, b[15:0]};
      sh    = (c == fn_sll || c == fn_srl || c == fn_sra) ? aux : a[4:0];
      by    = 8'(b >> {aux[1:0], 3'b000});   // little-endian byte lane
      hw    = aux[1] ? b[31:16] : b[15:0];
      res   = 32'h0;
      if (k == k_load) begin
         case (c)
            op_lb:   res = {{24{by[7]}}, by};
            op_lbu:  res = {24'h0, by};
            op_lh:   res = {{16{hw[15]}}, hw};
            op_lhu:  res = {16'h0, hw};
            default: res = b;
         endcase
      end else if (k == k_i_alu) begin
         case (c)
            op_addi, op_addiu: res = a + imm_s;
            op_slti: res = {31'd0, $signed(a) < $signed(imm_s)};
            op_andi: res = a & imm_z;
            op_ori:  res = a | imm_z;
            op_xori: res = a ^ imm_z;
            default: res = {b[15:0], 16'h0000};   // lui
         endcase
      end else begin
         case (c)
            fn_sll, fn_sllv: res = b << sh;
            fn_srl, fn_srlv: res = b >> sh;
            fn_sra, fn_srav: res = $signed(b) >>> sh;
            fn_add, fn_addu: res = a + b;
            fn_sub, fn_subu: res = a - b;
            fn_and:  res = a & b;
            fn_or:   res = a | b;
            fn_xor:  res = a ^ b;
            fn_nor:  res = ~(a | b);
            default: res = {31'd0, $signed(a) < $signed(b)};   // slt
         endcase
      end
      return res;
   endfunction

   task automatic add_row(string nm, kind_t k, logic [5:0] c, word_t a, word_t b,
                          logic [4:0] aux);
      row_t r;
      logic taken;
      taken = (a == b) ^ (c == op_bne);
      r = '{k, c, a, b, aux, 1, expected_word(k, c, a, b, aux), 32'd2};
      if (k == k_branch || k == k_jump || k == k_sys) begin
         r.n_exp = (k == k_branch && !taken) ? 2 : 1;   // marker 1 then 2 or 2 alone
         r.exp0  = (k == k_branch && !taken) ? 32'd1 : 32'd2;
      end else if (k == k_rsvd) begin
         r.n_exp = 0;
      end
      rows.push_back(r);
      names.push_back(nm);
   endtask

   task automatic emit(word_t w);
      rom[prog_idx] = w;
      prog_idx = prog_idx + 6'd1;
   endtask

   task automatic load_reg(reg_idx_t r, word_t v);
      emit(itype(op_lui, 5'd0, r, v[31:16]));
      emit(itype(op_ori, r, r, v[15:0]));
   endtask

   task automatic fill_rom();
      for (int i = 0; i < 64; i++)
         rom[i[5:0]] = {6'h3f, 20'h0, i[5:0]};   // reserved op tagged with its address
   endtask

   task automatic build_program(row_t r);
      word_t tgt;
      fill_rom();
      prog_idx = 6'd0;
      load_reg(5'd8, r.a);
      load_reg(5'd9, r.b);
      emit(itype(op_ori, 5'd0, 5'd11, 16'd1));   // marker 1
      emit(itype(op_ori, 5'd0, 5'd12, 16'd2));   // marker 2
      case (r.kind)
         k_r_alu:  emit(rtype(5'd8, 5'd9, 5'd10, r.aux, r.code));
         k_i_alu:  emit(itype(r.code, 5'd8, 5'd10, r.b[15:0]));
         k_load:   emit(itype(r.code, 5'd8, 5'd10, {11'h0, r.aux}));
         k_branch: emit(itype(r.code, 5'd8, 5'd9, 16'd1));   // skips one sw
         k_jump: begin
            if (r.code == op_j) begin
               tgt = text_start + {24'h0, prog_idx + 6'd2, 2'b00};
               emit({op_j, tgt[27:2]});
            end else begin
               tgt = text_start + {24'h0, prog_idx + 6'd4, 2'b00};   // past lui, ori, jr, sw
               load_reg(5'd13, tgt);
               emit(rtype(5'd13, 5'd0, 5'd0, 5'd0, fn_jr));
            end
         end
         k_sys: begin
            emit(itype(op_ori, 5'd0, 5'd2, 16'd5));   // v0 = 5 so no exit
            emit(rtype(5'd0, 5'd0, 5'd0, 5'd0, fn_syscall));
         end
         default: emit({r.code, 26'h0});
      endcase
      if (r.kind == k_branch || r.kind == k_jump)
         emit(itype(op_sw, 5'd0, 5'd11, 16'h0100));
      if (r.kind == k_r_alu || r.kind == k_i_alu || r.kind == k_load)
         emit(itype(op_sw, 5'd0, 5'd10, 16'h0100));   // result to word 0x40
      else
         emit(itype(op_sw, 5'd0, 5'd12, 16'h0100));
      emit(itype(op_ori, 5'd0, 5'd2, 16'd10));
      emit(rtype(5'd0, 5'd0, 5'd0, 5'd0, fn_syscall));
   endtask

   task automatic check_word(string nm, word_t exp, word_t act);
      if (exp !== act) begin
         $display("ERROR %s: expected %h, actual %h", nm, exp, act);
         err_count++;
      end
   endtask

   task automatic check_flag(string nm, logic exp, logic act);
      if (exp !== act) begin
         $display("ERROR %s: expected %b, actual %b", nm, exp, act);
         err_count++;
      end
   endtask

   task automatic wait_stores(string nm, int n);
      int cycles;
      cycles = 0;
      while (log_data.size() < n && cycles < 64) begin
         @(negedge clk);
         cycles++;
      end
      if (log_data.size() < n) begin
         $display("%s: timeout, the store to word 0x40 never came", nm);
         err_count++;
      end
   endtask

   task automatic wait_halt(string nm);
      int cycles;
      cycles = 0;
      while (halted !== 1'b1 && cycles < 64) begin
         @(negedge clk);
         cycles++;
      end
      if (halted !== 1'b1) begin
         $display("%s: timeout, the core never halted", nm);
         err_count++;
      end
   endtask

   task automatic run_test(row_t r, string nm);
      int errs;
      errs = err_count;
      @(negedge clk);
      ram_word = r.b;
      rst_b = 1'b0;
      build_program(r);
      repeat (16) @(negedge clk);
      rst_b = 1'b1;
      if (r.n_exp > 0)
         wait_stores(nm, r.n_exp);
      wait_halt(nm);
      repeat (8) begin   // parked core makes no writes
         @(negedge clk);
         check_flag({nm, " halted"}, 1'b1, halted);
         check_flag({nm, " mem_write_en"}, 1'b0, |mem_write_en);
      end
      if (log_data.size() != r.n_exp) begin
         $display("ERROR %s store count: expected %0d, actual %0d",
                  nm, r.n_exp, log_data.size());
         err_count++;
      end else begin
         for (int i = 0; i < r.n_exp; i++) begin
            check_word({nm, " data"}, (i == 0) ? r.exp0 : r.exp1, log_data[i]);
            check_word({nm, " addr"}, 32'h40, {2'b00, log_addr[i]});
         end
      end
      if (err_count == errs) begin
         $display("%s: pass", nm);
      end else begin
         $display("%s: FAIL", nm);
         fail_count++;
      end
   endtask

   initial begin
      word_t v;
      rst_b    = 1'b0;
      ram_word = 32'h0;
      fill_rom();
      add_row("add",  k_r_alu, fn_add,  random_word(), random_word(), 5'd0);
      add_row("addu", k_r_alu, fn_addu, random_word(), random_word(), 5'd0);
      add_row("sub",  k_r_alu, fn_sub,  random_word(), random_word(), 5'd0);
      add_row("subu", k_r_alu, fn_subu, random_word(), random_word(), 5'd0);
      add_row("and",  k_r_alu, fn_and,  random_word(), random_word(), 5'd0);
      add_row("or",   k_r_alu, fn_or,   random_word(), random_word(), 5'd0);
      add_row("xor",  k_r_alu, fn_xor,  random_word(), random_word(), 5'd0);
      add_row("nor",  k_r_alu, fn_nor,  random_word(), random_word(), 5'd0);
      add_row("slt",  k_r_alu, fn_slt,  random_word(), random_word(), 5'd0);
      add_row("sll",  k_r_alu, fn_sll,  32'h0, random_word(), 5'd7);
      add_row("srl",  k_r_alu, fn_srl,  32'h0, random_word(), 5'd13);
      add_row("sra_31", k_r_alu, fn_sra, 32'h0, random_word() | 32'h8000_0000, 5'd31);
      add_row("sllv", k_r_alu, fn_sllv, random_word(), random_word(), 5'd0);
      add_row("srlv", k_r_alu, fn_srlv, random_word(), random_word(), 5'd0);
      add_row("srav_31", k_r_alu, fn_srav, 32'd31, random_word() | 32'h8000_0000, 5'd0);
      add_row("add_zero", k_r_alu, fn_add, 32'h0, 32'h0, 5'd0);
      add_row("sub_neg",  k_r_alu, fn_sub, 32'd5, 32'd9, 5'd0);
      add_row("slt_neg",  k_r_alu, fn_slt, 32'hffff_ffff, 32'd1, 5'd0);
      add_row("addi_neg", k_i_alu, op_addi, random_word(), 32'h0000_8001, 5'd0);
      add_row("addiu", k_i_alu, op_addiu, random_word(), random_word(), 5'd0);
      add_row("slti",  k_i_alu, op_slti,  random_word(), random_word(), 5'd0);
      add_row("slti_neg", k_i_alu, op_slti, 32'd5, 32'h0000_fff0, 5'd0);   // imm is -16
      add_row("andi",  k_i_alu, op_andi,  random_word(), random_word() | 32'h8000, 5'd0);
      add_row("ori",   k_i_alu, op_ori,   random_word(), random_word() | 32'h8000, 5'd0);
      add_row("xori",  k_i_alu, op_xori,  random_word(), random_word() | 32'h8000, 5'd0);
      add_row("lui",   k_i_alu, op_lui,   random_word(), random_word(), 5'd0);
      for (int o = 0; o < 4; o++) begin   // every byte lane of word 8c7fe501
         add_row($sformatf("lb_%0d", o),  k_load, op_lb,  32'h80, 32'h8c7f_e501, o[4:0]);
         add_row($sformatf("lbu_%0d", o), k_load, op_lbu, 32'h80, 32'h8c7f_e501, o[4:0]);
         if (o[0] == 1'b0) begin
            add_row($sformatf("lh_%0d", o),  k_load, op_lh,  32'h80, 32'h8c7f_e501, o[4:0]);
            add_row($sformatf("lhu_%0d", o), k_load, op_lhu, 32'h80, 32'h8c7f_e501, o[4:0]);
         end
      end
      add_row("lw", k_load, op_lw, 32'h80, random_word(), 5'd0);
      v = random_word();
      add_row("beq_taken", k_branch, op_beq, v, v, 5'd0);
      add_row("beq_not",   k_branch, op_beq, v, v + 32'd1, 5'd0);
      add_row("bne_taken", k_branch, op_bne, v, ~v, 5'd0);
      add_row("bne_not",   k_branch, op_bne, v, v, 5'd0);
      add_row("j",  k_jump, op_j,  random_word(), random_word(), 5'd0);
      add_row("jr", k_jump, fn_jr, random_word(), random_word(), 5'd0);
      add_row("syscall_v0_5", k_sys, op_special, random_word(), random_word(), 5'd0);
      add_row("rsvd_op3f", k_rsvd, 6'h3f, random_word(), random_word(), 5'd0);
      add_row("rsvd_op01", k_rsvd, 6'h01, random_word(), random_word(), 5'd0);

      foreach (rows[t])
         run_test(rows[t], names[t]);

      $display("%0d tests, %0d failed, %0d check errors", rows.size(), fail_count, err_count);
      if (err_count == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

// File: src.f
hw/mips_pkg.sv
hw/mips_fetch.sv
hw/mips_decode.sv
hw/mips_regfile.sv
hw/mips_alu.sv
hw/mips_core.sv
sim/tb_mips_core.sv

// File: run.sh
#!/bin/sh
# build the core testbench with verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module tb_mips_core \
   -f src.f -Mdir obj_dir -o tb_mips_core
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/tb_mips_core)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "Test OK"; then
   exit 0
fi
exit 1
